// File: Makefile
# Verilator build and run of the tx mmu register block testbench

VERILATOR ?= verilator
TOP       ?= mmu_tx_regs_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Simulation failed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "run failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/mmu_tx_regs_checks.svh
// **********************************************************
// reference model, random source and compare tasks
// needs the model state and error counters declared first
// **********************************************************
`ifndef MMU_TX_REGS_CHECKS_SVH
`define MMU_TX_REGS_CHECKS_SVH

function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
endfunction

function automatic logic [23:0] reg_addr(input logic [11:0] id, input logic [1:0] grp,
                                         input logic [6:0] off);
        return {id, 3'b000, grp, off};
endfunction

// expected read word, zero for anything outside the kept map
function automatic mmu_tx_regs_pkg::reg_word_t expected_word(input logic [23:0] addr);
        logic [6:0] off;
        mmu_tx_regs_pkg::reg_word_t word;
        off = addr[6:0];
        word = '0;
        if (addr[23:12] == 12'h001 && addr[11:9] == 3'b000) begin
                case (addr[8:7])
                        2'd0: word = (off == 7'h00) ? {21'd0, m_beat} : '0;
                        2'd1: word = (off == 7'h00) ? m_err : '0;
                        2'd2: begin
                                case (off)
                                        7'h00: word = status.pkt_sta;
                                        7'h01: word = {21'd0, status.hacc_sn};
                                        7'h0c: word = {21'd0, status.ddr_rsp_sn};
                                        7'h0d: word = {29'd0, status.seq_info};
                                        7'h0e: word = {5'd0, status.online_beat, 10'd0,
                                                       status.bd_sta};
                                        default: word = '0;
                                endcase
                        end
                        default: begin
                                if (off < 7'd14) begin
                                        word = m_cnt[off[3:0]];
                                end
                        end
                endcase
        end
        return word;
endfunction

task automatic check_word(input string name, input mmu_tx_regs_pkg::reg_word_t got,
                          input mmu_tx_regs_pkg::reg_word_t exp);
        check_cnt++;
        if (got !== exp) begin
                mismatch_cnt++;
                $display("Mismatch %s: got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
        end
endtask

task automatic check_beat(input string name, input mmu_tx_regs_pkg::beat_t got,
                          input mmu_tx_regs_pkg::beat_t exp);
        check_cnt++;
        if (got !== exp) begin
                mismatch_cnt++;
                $display("Mismatch %s: got 0x%03h expected 0x%03h at %0t", name, got, exp, $time);
        end
endtask

task automatic report_fault(input string msg);
        other_cnt++;
        $display("Error: %s at %0t", msg, $time);
endtask

`endif

// File: dv/mmu_tx_regs_tb.sv
// **********************************************************
// random register traffic checked against a model of the map
// events and error flags stay quiet while reads are issued
// **********************************************************
`default_nettype none
`timescale 1ns/1ns

module mmu_tx_regs_tb;

        localparam int rst_cycles = 10;
        localparam int ev_cycles = 200;
        localparam int err_rounds = 4;
        localparam int err_pulses = 16;
        // reads, writes and gaps outside the event and error loops
        localparam int misc_cycles = 200;
        localparam int run_cycles = rst_cycles + 2 * (ev_cycles + 14) +
                                    err_rounds * (err_pulses + 4) + misc_cycles;

        logic clk_sys = 1'b0;
        logic rst = 1'b1;
        mmu_tx_regs_pkg::cpu_req_t cpu_req = '0;
        mmu_tx_regs_pkg::tx_status_t status = '0;
        mmu_tx_regs_pkg::reg_word_t err_flags = '0;
        mmu_tx_regs_pkg::cnt_event_t events = '0;
        logic cnt_clr = 1'b0;
        mmu_tx_regs_pkg::beat_t online_beat;
        mmu_tx_regs_pkg::reg_word_t rd_data;
        logic rd_valid;

        // model state
        logic [31:0] lcg_state = 32'h7b5e;
        mmu_tx_regs_pkg::beat_t m_beat = 11'h350;
        mmu_tx_regs_pkg::reg_word_t m_err = '0;
        mmu_tx_regs_pkg::reg_word_t m_cnt [14];
        mmu_tx_regs_pkg::reg_word_t exp_q [$];
        int issue_q [$];
        int cyc = 0;
        int check_cnt = 0;
        int mismatch_cnt = 0;
        int other_cnt = 0;

        `include "mmu_tx_regs_checks.svh"

        mmu_tx_regs dut_i (
                .clk_sys     (clk_sys),
                .rst         (rst),
                .cpu_req     (cpu_req),
                .status      (status),
                .err_flags   (err_flags),
                .events      (events),
                .cnt_clr     (cnt_clr),
                .online_beat (online_beat),
                .rd_data     (rd_data),
                .rd_valid    (rd_valid)
        );

        always #4 clk_sys = ~clk_sys;

        always @(posedge clk_sys) begin
                cyc <= cyc + 1;
        end

        // responses come back in issue order two edges after issue
        always @(negedge clk_sys) begin
                if (!rst && rd_valid) begin
                        if (exp_q.size() == 0) begin
                                report_fault("rd_valid without an outstanding read");
                        end else begin
                                if (cyc - issue_q[0] != 2) begin
                                        report_fault("read did not return two cycles after rd");
                                end
                                check_word("rd_data", rd_data, exp_q.pop_front());
                                void'(issue_q.pop_front());
                        end
                end
        end

        task automatic quiet();
                cpu_req = '0;
                err_flags = '0;
                events = '0;
                cnt_clr = 1'b0;
        endtask

        task automatic read_reg(input logic [23:0] addr);
                quiet();
                cpu_req.rd = 1'b1;
                cpu_req.addr = addr;
                exp_q.push_back(expected_word(addr));
                issue_q.push_back(cyc);
                @(negedge clk_sys);
        endtask

        task automatic write_reg(input logic [23:0] addr, input logic [31:0] data);
                quiet();
                cpu_req.wr = 1'b1;
                cpu_req.addr = addr;
                cpu_req.wdata = data;
                if (addr == 24'h001000) begin
                        m_beat = data[10:0];
                end else if (addr == 24'h001080) begin
                        m_err = m_err & ~data;
                end
                @(negedge clk_sys);
        endtask

        task automatic pulse_inputs(input logic [31:0] flags, input logic [13:0] ev,
                                    input logic clr);
                quiet();
                err_flags = flags;
                events = ev;
                cnt_clr = clr;
                m_err = m_err | flags;
                for (int i = 0; i < 14; i++) begin
                        if (clr) begin
                                m_cnt[i] = '0;
                        end else if (ev[i]) begin
                                m_cnt[i] = m_cnt[i] + 32'd1;
                        end
                end
                @(negedge clk_sys);
        endtask

        task automatic read_counters();
                for (int i = 0; i < 14; i++) begin
                        read_reg(reg_addr(12'h001, 2'd3, 7'(i)));
                end
        endtask

        initial begin
                logic [31:0] r;
                logic [95:0] sts_bits;
                for (int i = 0; i < 14; i++) begin
                        m_cnt[i] = '0;
                end
                repeat (rst_cycles) @(posedge clk_sys);
                @(negedge clk_sys);
                rst = 1'b0;

                // reset values
                check_beat("online_beat", online_beat, 11'h350);
                check_word("rd_data", rd_data, '0);
                if (rd_valid !== 1'b0) begin
                        report_fault("rd_valid is high after reset");
                end
                read_reg(reg_addr(12'h001, 2'd0, 7'h00));
                read_reg(reg_addr(12'h001, 2'd1, 7'h00));
                read_counters();

                // configuration, then writes that miss the block
                r = next_rand();
                write_reg(reg_addr(12'h001, 2'd0, 7'h00), r);
                check_beat("online_beat", online_beat, r[10:0]);
                read_reg(reg_addr(12'h001, 2'd0, 7'h00));
                write_reg(reg_addr(12'h002, 2'd0, 7'h00), ~r);
                write_reg(24'h001200, ~r);
                check_beat("online_beat", online_beat, r[10:0]);
                read_reg(reg_addr(12'h001, 2'd0, 7'h00));

                // sticky error bits and write-1 clear
                for (int k = 0; k < err_rounds; k++) begin
                        for (int j = 0; j < err_pulses; j++) begin
                                pulse_inputs(next_rand() & next_rand() & next_rand(), '0, 1'b0);
                        end
                        read_reg(reg_addr(12'h001, 2'd1, 7'h00));
                        write_reg(reg_addr(12'h001, 2'd1, 7'h00), next_rand());
                        read_reg(reg_addr(12'h001, 2'd1, 7'h00));
                end

                // status words including dropped offsets
                for (int k = 0; k < 3; k++) begin
                        sts_bits = {next_rand(), next_rand(), next_rand()};
                        status = sts_bits[73:0];
                        for (int i = 0; i < 16; i++) begin
                                read_reg(reg_addr(12'h001, 2'd2, 7'(i)));
                        end
                end
                read_reg(reg_addr(12'h001, 2'd2, 7'h40));
                read_reg(reg_addr(12'h001, 2'd0, 7'h01));
                read_reg(reg_addr(12'h001, 2'd1, 7'h05));
                read_reg(reg_addr(12'h001, 2'd3, 7'd14));
                read_reg(reg_addr(12'h001, 2'd3, 7'h7f));
                read_reg(reg_addr(12'h000, 2'd0, 7'h00));
                read_reg(reg_addr(12'h801, 2'd1, 7'h00));
                read_reg(24'h001280);

                // counters
                for (int k = 0; k < 2; k++) begin
                        repeat (ev_cycles) begin
                                r = next_rand();
                                pulse_inputs('0, r[30:17], 1'b0);
                        end
                        read_counters();
                end
                pulse_inputs('0, 14'h3fff, 1'b1);
                read_counters();

                quiet();
                repeat (4) @(negedge clk_sys);
                if (exp_q.size() != 0) begin
                        report_fault("reads left without rd_valid");
                end
                $display("checks %0d, mismatches %0d, other errors %0d",
                         check_cnt, mismatch_cnt, other_cnt);
                if (mismatch_cnt == 0 && other_cnt == 0) begin
                        $display("Simulation completed successfully");
                end else begin
                        $display("Simulation failed");
                end
                $finish;
        end

        initial begin
                #(run_cycles * 8 + 1000);
                $display("watchdog expired, %0d reads still pending", exp_q.size());
                $display("Simulation failed");
                $finish;
        end

endmodule

`default_nettype wire

// File: flist.f
+incdir+dv
verilog/mmu_tx_regs_pkg.sv
verilog/mmu_tx_ctrl_regs.sv
verilog/mmu_tx_cnt_bank.sv
verilog/mmu_tx_rd_mux.sv
verilog/mmu_tx_regs.sv
dv/mmu_tx_regs_tb.sv

// File: verilog/mmu_tx_cnt_bank.sv
// **********************************************************
// fourteen wrapping event counters with first read stage
// cnt_clr is a level and beats any increment
// **********************************************************
`default_nettype none
`timescale 1ns/1ns

module mmu_tx_cnt_bank (
        input  wire                                clk_sys,
        input  wire                                rst,
        input  wire mmu_tx_regs_pkg::cpu_req_t     cpu_req,
        input  wire mmu_tx_regs_pkg::cnt_event_t   events,
        input  wire                                cnt_clr,
        output mmu_tx_regs_pkg::reg_word_t         cnt_word
);

        localparam int cnt_num = mmu_tx_regs_pkg::cnt_num;

        logic [cnt_num-1:0] ev;
        logic [mmu_tx_regs_pkg::off_w-1:0] off;
        mmu_tx_regs_pkg::reg_word_t cnt_q [cnt_num];
        mmu_tx_regs_pkg::reg_word_t cnt_sel;

        // struct field order already matches the counter index
        assign ev = events;
        assign off = mmu_tx_regs_pkg::addr_off(cpu_req.addr);

        always_ff @(posedge clk_sys or posedge rst) begin
                if (rst) begin
                        for (int i = 0; i < cnt_num; i++) begin
                                cnt_q[i] <= '0;
                        end
                end else if (cnt_clr) begin
                        for (int i = 0; i < cnt_num; i++) begin
                                cnt_q[i] <= '0;
                        end
                end else begin
                        for (int i = 0; i < cnt_num; i++) begin
                                if (ev[i]) begin
                                        cnt_q[i] <= cnt_q[i] + 1'b1;
                                end
                        end
                end
        end

        // offsets past the last counter read zero
        always_comb begin
                cnt_sel = '0;
                for (int i = 0; i < cnt_num; i++) begin
                        if (int'(off) == i) begin
                                cnt_sel = cnt_q[i];
                        end
                end
        end

        always_ff @(posedge clk_sys) begin
                cnt_word <= cnt_sel;
        end

        for (genvar g = 0; g < cnt_num; g++) begin : g_step_chk
                a_cnt_step: assert property (@(posedge clk_sys) disable iff (rst)
                        !$past(cnt_clr) |->
                        (mmu_tx_regs_pkg::reg_word_t'(cnt_q[g] - $past(cnt_q[g])) <= 32'd1));
        end

endmodule

`default_nettype wire

// File: verilog/mmu_tx_ctrl_regs.sv
// **********************************************************
// cfg, sticky error and status words with first read stage
// only offset 0 is mapped in the cfg and err groups
// **********************************************************
`default_nettype none
`timescale 1ns/1ns

module mmu_tx_ctrl_regs (
        input  wire                                clk_sys,
        input  wire                                rst,
        input  wire mmu_tx_regs_pkg::cpu_req_t     cpu_req,
        input  wire mmu_tx_regs_pkg::tx_status_t   status,
        input  wire mmu_tx_regs_pkg::reg_word_t    err_flags,
        output mmu_tx_regs_pkg::beat_t             online_beat,
        output mmu_tx_regs_pkg::reg_word_t         ctrl_word,
        output mmu_tx_regs_pkg::reg_group_e        group_sel
);

        logic [mmu_tx_regs_pkg::off_w-1:0] off;
        mmu_tx_regs_pkg::reg_group_e grp;
        logic wr_hit;
        logic cfg_wr;
        logic err_wr;
        mmu_tx_regs_pkg::reg_word_t err_q;
        mmu_tx_regs_pkg::reg_word_t err_clr;
        mmu_tx_regs_pkg::reg_word_t sts_word;
        mmu_tx_regs_pkg::reg_word_t sel_word;

        assign off = mmu_tx_regs_pkg::addr_off(cpu_req.addr);
        assign grp = mmu_tx_regs_pkg::addr_group(cpu_req.addr);

        // **********************************************************
        // write side
        // **********************************************************
        assign wr_hit = cpu_req.wr && mmu_tx_regs_pkg::blk_match(cpu_req.addr);
        assign cfg_wr = wr_hit && (grp == mmu_tx_regs_pkg::grp_cfg) &&
                        (off == mmu_tx_regs_pkg::cfg_off);
        assign err_wr = wr_hit && (grp == mmu_tx_regs_pkg::grp_err) &&
                        (off == mmu_tx_regs_pkg::err_off);
        assign err_clr = err_wr ? cpu_req.wdata : '0;

        always_ff @(posedge clk_sys or posedge rst) begin
                if (rst) begin
                        online_beat <= mmu_tx_regs_pkg::beat_init;
                end else if (cfg_wr) begin
                        online_beat <= cpu_req.wdata[mmu_tx_regs_pkg::beat_w-1:0];
                end
        end

        // set has priority over a write-1 clear in the same cycle
        always_ff @(posedge clk_sys or posedge rst) begin
                if (rst) begin
                        err_q <= '0;
                end else begin
                        err_q <= (err_q & ~err_clr) | err_flags;
                end
        end

        // **********************************************************
        // read side
        // **********************************************************
        always_comb begin
                case (off)
                        mmu_tx_regs_pkg::sts_pkt_sta:
                                sts_word = status.pkt_sta;
                        mmu_tx_regs_pkg::sts_hacc_sn:
                                sts_word = {21'd0, status.hacc_sn};
                        mmu_tx_regs_pkg::sts_ddr_rsp_sn:
                                sts_word = {21'd0, status.ddr_rsp_sn};
                        mmu_tx_regs_pkg::sts_seq_info:
                                sts_word = {29'd0, status.seq_info};
                        mmu_tx_regs_pkg::sts_beat_bd:
                                sts_word = {5'd0, status.online_beat, 10'd0, status.bd_sta};
                        default:
                                sts_word = '0;
                endcase
        end

        // counter group is served by the counter bank
        always_comb begin
                sel_word = '0;
                case (grp)
                        mmu_tx_regs_pkg::grp_cfg: begin
                                if (off == mmu_tx_regs_pkg::cfg_off) begin
                                        sel_word = mmu_tx_regs_pkg::reg_word_t'(online_beat);
                                end
                        end
                        mmu_tx_regs_pkg::grp_err: begin
                                if (off == mmu_tx_regs_pkg::err_off) begin
                                        sel_word = err_q;
                                end
                        end
                        mmu_tx_regs_pkg::grp_sts: begin
                                sel_word = sts_word;
                        end
                        default: begin
                                sel_word = '0;
                        end
                endcase
        end

        always_ff @(posedge clk_sys or posedge rst) begin
                if (rst) begin
                        group_sel <= mmu_tx_regs_pkg::grp_cfg;
                end else begin
                        group_sel <= grp;
                end
        end

        always_ff @(posedge clk_sys) begin
                ctrl_word <= sel_word;
        end

        a_rd_wr_excl: assert property (@(posedge clk_sys) disable iff (rst)
                !(cpu_req.rd && cpu_req.wr));

endmodule

`default_nettype wire

// File: verilog/mmu_tx_rd_mux.sv
// **********************************************************
// block match, second read stage and read-valid strobe
// rd_data is only meaningful while rd_valid is high
// **********************************************************
`default_nettype none
`timescale 1ns/1ns

module mmu_tx_rd_mux (
        input  wire                                clk_sys,
        input  wire                                rst,
        input  wire mmu_tx_regs_pkg::cpu_req_t     cpu_req,
        input  wire mmu_tx_regs_pkg::reg_word_t    ctrl_word,
        input  wire mmu_tx_regs_pkg::reg_word_t    cnt_word,
        input  wire mmu_tx_regs_pkg::reg_group_e   group_sel,
        output mmu_tx_regs_pkg::reg_word_t         rd_data,
        output logic                               rd_valid
);

        logic rd_q;
        logic blk_q;

        // runs alongside the first word stage
        always_ff @(posedge clk_sys or posedge rst) begin
                if (rst) begin
                        rd_q <= 1'b0;
                        blk_q <= 1'b0;
                end else begin
                        rd_q <= cpu_req.rd;
                        blk_q <= mmu_tx_regs_pkg::blk_match(cpu_req.addr);
                end
        end

        always_ff @(posedge clk_sys or posedge rst) begin
                if (rst) begin
                        rd_data <= '0;
                        rd_valid <= 1'b0;
                end else begin
                        rd_valid <= rd_q;
                        if (!blk_q) begin
                                rd_data <= '0;
                        end else if (group_sel == mmu_tx_regs_pkg::grp_cnt) begin
                                rd_data <= cnt_word;
                        end else begin
                                rd_data <= ctrl_word;
                        end
                end
        end

        a_rd_lat: assert property (@(posedge clk_sys) disable iff (rst)
                cpu_req.rd |-> ##2 rd_valid);

        a_no_spurious_vld: assert property (@(posedge clk_sys) disable iff (rst)
                rd_valid |-> $past(cpu_req.rd, 2));

endmodule

`default_nettype wire

// File: verilog/mmu_tx_regs.sv
// **********************************************************
// tx mmu register block top, no back-pressure on the cpu port
// rd and wr are single-cycle strobes, never both at once
// **********************************************************
`default_nettype none
`timescale 1ns/1ns

module mmu_tx_regs (
        input  wire                                clk_sys,
        input  wire                                rst,
        input  wire mmu_tx_regs_pkg::cpu_req_t     cpu_req,
        input  wire mmu_tx_regs_pkg::tx_status_t   status,
        input  wire mmu_tx_regs_pkg::reg_word_t    err_flags,
        input  wire mmu_tx_regs_pkg::cnt_event_t   events,
        input  wire                                cnt_clr,
        output mmu_tx_regs_pkg::beat_t             online_beat,
        output mmu_tx_regs_pkg::reg_word_t         rd_data,
        output logic                               rd_valid
);

        // first stage words
        mmu_tx_regs_pkg::reg_word_t ctrl_word;
        mmu_tx_regs_pkg::reg_word_t cnt_word;
        mmu_tx_regs_pkg::reg_group_e group_sel;

        mmu_tx_ctrl_regs ctrl_regs_i (
                .clk_sys     (clk_sys),
                .rst         (rst),
                .cpu_req     (cpu_req),
                .status      (status),
                .err_flags   (err_flags),
                .online_beat (online_beat),
                .ctrl_word   (ctrl_word),
                .group_sel   (group_sel)
        );

        mmu_tx_cnt_bank cnt_bank_i (
                .clk_sys  (clk_sys),
                .rst      (rst),
                .cpu_req  (cpu_req),
                .events   (events),
                .cnt_clr  (cnt_clr),
                .cnt_word (cnt_word)
        );

        mmu_tx_rd_mux rd_mux_i (
                .clk_sys   (clk_sys),
                .rst       (rst),
                .cpu_req   (cpu_req),
                .ctrl_word (ctrl_word),
                .cnt_word  (cnt_word),
                .group_sel (group_sel),
                .rd_data   (rd_data),
                .rd_valid  (rd_valid)
        );

endmodule

`default_nettype wire

// File: verilog/mmu_tx_regs_pkg.sv
// **********************************************************
// address map and port types of the tx mmu register block
// block id and ddr channel count are fixed for every instance
// **********************************************************
`default_nettype none

package mmu_tx_regs_pkg;

        // address is block id on top, then a zero field, group and word offset
        localparam int addr_w = 24;
        localparam int data_w = 32;
        localparam int id_w = 12;
        localparam int off_w = 7;
        localparam int grp_lsb = off_w;
        localparam int zero_w = addr_w - id_w - 2 - off_w;
        localparam logic [id_w-1:0] mmu_tx_cm_id = 12'h001;

        localparam int ddr_num = 4;
        localparam int beat_w = 11;
        localparam logic [beat_w-1:0] beat_init = 11'h350;
        localparam int cnt_num = 14;

        // word offsets inside a group
        localparam logic [off_w-1:0] cfg_off = 7'h00;
        localparam logic [off_w-1:0] err_off = 7'h00;
        localparam logic [off_w-1:0] sts_pkt_sta = 7'h00;
        localparam logic [off_w-1:0] sts_hacc_sn = 7'h01;
        localparam logic [off_w-1:0] sts_ddr_rsp_sn = 7'h0c;
        localparam logic [off_w-1:0] sts_seq_info = 7'h0d;
        localparam logic [off_w-1:0] sts_beat_bd = 7'h0e;

        typedef logic [data_w-1:0] reg_word_t;
        typedef logic [beat_w-1:0] beat_t;

        typedef enum logic [1:0] {
                grp_cfg = 2'd0,
                grp_err = 2'd1,
                grp_sts = 2'd2,
                grp_cnt = 2'd3
        } reg_group_e;

        typedef struct packed {
                logic rd;
                logic wr;
                logic [addr_w-1:0] addr;
                reg_word_t wdata;
        } cpu_req_t;

        typedef struct packed {
                reg_word_t pkt_sta;
                logic [10:0] hacc_sn;
                logic [10:0] ddr_rsp_sn;
                logic [2:0] seq_info;
                beat_t online_beat;
                logic [5:0] bd_sta;
        } tx_status_t;

        // field order gives the counter index, tx_cnt is counter 0
        typedef struct packed {
                logic [ddr_num-1:0] rsp_ok;
                logic [ddr_num-1:0] send_ok;
                logic tx2rx_bd_wen;
                logic kernel_bd_wen;
                logic ddr_rsp;
                logic rxffc_wr;
                logic inq_fifo_rd;
                logic tx_cnt;
        } cnt_event_t;

        function automatic logic blk_match(input logic [addr_w-1:0] addr);
                return (addr[addr_w-1 -: id_w] == mmu_tx_cm_id) &&
                       (addr[grp_lsb+2 +: zero_w] == '0);
        endfunction

        function automatic reg_group_e addr_group(input logic [addr_w-1:0] addr);
                return reg_group_e'(addr[grp_lsb +: 2]);
        endfunction

        function automatic logic [off_w-1:0] addr_off(input logic [addr_w-1:0] addr);
                return addr[off_w-1:0];
        endfunction

endpackage

`default_nettype wire
